//--- verilog/dsp_cfg_pkg.sv
`default_nettype none

package dsp_cfg_pkg;

    //Equalizer and slicer
    localparam int FFE_TAPS  = 3;
    localparam int WEIGHT_W  = 8;
    localparam int SHIFT_W   = 3;
    localparam int THRESH_W  = 12;
    localparam int FFE_OUT_W = 19;

    //Channel estimate
    localparam int CHAN_TAPS = 3;
    localparam int CHAN_W    = 8;
    localparam int EST_W     = 10;

    //Register map
    localparam logic [7:0] ADDR_FFE_W      = 8'h00;
    localparam logic [7:0] ADDR_FFE_CTL    = 8'h04;
    localparam logic [7:0] ADDR_CHAN       = 8'h08;
    localparam logic [7:0] ADDR_CHAN_SHIFT = 8'h0C;
    localparam int         THRESH_LSB      = 8;

    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [CHAN_W-1:0]   chan_tap_t;

    typedef struct packed {
        weight_t   [FFE_TAPS-1:0]  ffe_w;
        logic      [SHIFT_W-1:0]   ffe_shift;
        logic signed [THRESH_W-1:0] thresh;
        chan_tap_t [CHAN_TAPS-1:0] chan_w;
        logic      [SHIFT_W-1:0]   chan_shift;
    } dsp_cfg_t;

endpackage : dsp_cfg_pkg

`default_nettype wire

//--- verilog/dsp_data_pkg.sv
`default_nettype none

package dsp_data_pkg;

    //Block geometry
    localparam int LANES  = 4;
    localparam int CODE_W = 8;
    localparam int ERR_W  = 11;

    typedef logic signed [CODE_W-1:0] code_t;
    typedef logic signed [ERR_W-1:0]  err_t;

    //Lane 0 holds the oldest sample of a block
    typedef code_t [LANES-1:0] code_block_t;
    typedef logic  [LANES-1:0] bit_block_t;
    typedef err_t  [LANES-1:0] err_block_t;

    //Tap 0 is the newest code of the window
    typedef code_t [dsp_cfg_pkg::FFE_TAPS-1:0] code_window_t;

endpackage : dsp_data_pkg

`default_nettype wire

//--- verilog/apb_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_cfg_regs (
    input  logic                  clk_i,
    input  logic                  reset_i,

    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [7:0]            paddr_i,
    input  logic [31:0]           pwdata_i,
    output logic [31:0]           prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,

    output dsp_cfg_pkg::dsp_cfg_t cfg_o
);
    import dsp_cfg_pkg::*;

    dsp_cfg_t    cfg_q;
    logic        access;
    logic        addr_hit;
    logic [31:0] rdata;

    assign access = psel_i & penable_i;

    //Read mux and address decode
    always_comb begin
        addr_hit = 1'b1;
        rdata    = '0;
        case (paddr_i)
            ADDR_FFE_W: begin
                rdata[FFE_TAPS*WEIGHT_W-1:0] = cfg_q.ffe_w;
            end
            ADDR_FFE_CTL: begin
                rdata[SHIFT_W-1:0]             = cfg_q.ffe_shift;
                rdata[THRESH_LSB +: THRESH_W] = cfg_q.thresh;
            end
            ADDR_CHAN: begin
                rdata[CHAN_TAPS*CHAN_W-1:0] = cfg_q.chan_w;
            end
            ADDR_CHAN_SHIFT: begin
                rdata[SHIFT_W-1:0] = cfg_q.chan_shift;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_q <= '0;
        end else if (access && pwrite_i) begin
            case (paddr_i)
                ADDR_FFE_W: cfg_q.ffe_w <= pwdata_i[FFE_TAPS*WEIGHT_W-1:0];
                ADDR_FFE_CTL: begin
                    cfg_q.ffe_shift <= pwdata_i[SHIFT_W-1:0];
                    cfg_q.thresh    <= pwdata_i[THRESH_LSB +: THRESH_W];
                end
                ADDR_CHAN:       cfg_q.chan_w     <= pwdata_i[CHAN_TAPS*CHAN_W-1:0];
                ADDR_CHAN_SHIFT: cfg_q.chan_shift <= pwdata_i[SHIFT_W-1:0];
                default: ;
            endcase
        end
    end

    //Zero wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access & ~addr_hit;
    assign prdata_o  = rdata;
    assign cfg_o     = cfg_q;

endmodule : apb_cfg_regs

`default_nettype wire

//--- verilog/code_history.sv
`timescale 1ns/1ps
`default_nettype none

module code_history (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       valid_i,
    input  dsp_data_pkg::code_block_t  codes_i,
    output dsp_data_pkg::code_window_t [dsp_data_pkg::LANES-1:0] windows_o
);
    import dsp_data_pkg::*;
    import dsp_cfg_pkg::*;

    code_block_t           prev_q;
    code_t [2*LANES-1:0]   hist;

    //Previous valid block only
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            prev_q <= '0;
        end else if (valid_i) begin
            prev_q <= codes_i;
        end
    end

    //Sample stream across the block boundary, oldest at index 0
    assign hist = {codes_i, prev_q};

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            for (int j = 0; j < FFE_TAPS; j++) begin
                windows_o[i][j] = hist[LANES+i-j];
            end
        end
    end

endmodule : code_history

`default_nettype wire

//--- verilog/ffe_lane.sv
`timescale 1ns/1ps
`default_nettype none

module ffe_lane (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  dsp_data_pkg::code_window_t  window_i,
    input  dsp_cfg_pkg::dsp_cfg_t       cfg_i,
    output logic                        bit_o
);
    import dsp_cfg_pkg::*;

    logic signed [FFE_OUT_W-1:0] ffe_sum;
    logic signed [FFE_OUT_W-1:0] ffe_shifted;
    logic signed [FFE_OUT_W-1:0] thresh_ext;
    logic                        slice;

    //Full precision multiply accumulate
    always_comb begin
        logic signed [FFE_OUT_W-1:0] code;
        logic signed [FFE_OUT_W-1:0] weight;
        ffe_sum = '0;
        for (int t = 0; t < FFE_TAPS; t++) begin
            code    = window_i[t];
            weight  = cfg_i.ffe_w[t];
            ffe_sum = ffe_sum + code * weight;
        end
    end

    assign ffe_shifted = ffe_sum >>> cfg_i.ffe_shift;
    assign thresh_ext  = cfg_i.thresh;

    //Slicer
    assign slice = (ffe_shifted >= thresh_ext);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            bit_o <= 1'b0;
        end else begin
            bit_o <= slice;
        end
    end

endmodule : ffe_lane

`default_nettype wire

//--- verilog/delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output payload_t data_o,
    output logic     valid_o
);
    payload_t           data_q [DEPTH];
    logic [DEPTH-1:0]   valid_q;

    always_ff @(posedge clk_i) begin
        data_q[0] <= data_i;
        for (int s = 1; s < DEPTH; s++) begin
            data_q[s] <= data_q[s-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= valid_i;
            for (int s = 1; s < DEPTH; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    assign data_o  = data_q[DEPTH-1];
    assign valid_o = valid_q[DEPTH-1];

endmodule : delay_line

`default_nettype wire

//--- verilog/channel_error.sv
`timescale 1ns/1ps
`default_nettype none

module channel_error (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       valid_i,
    input  dsp_data_pkg::bit_block_t   bits_i,
    input  dsp_data_pkg::code_block_t  codes_i,
    input  dsp_cfg_pkg::dsp_cfg_t      cfg_i,
    output dsp_data_pkg::err_block_t   err_o,
    output logic                       valid_o
);
    import dsp_data_pkg::*;
    import dsp_cfg_pkg::*;

    bit_block_t            prev_bits_q;
    logic [2*LANES-1:0]    bit_hist;
    err_block_t            err_d;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            prev_bits_q <= '0;
        end else if (valid_i) begin
            prev_bits_q <= bits_i;
        end
    end

    assign bit_hist = {bits_i, prev_bits_q};

    //Rebuild each code from the channel estimate
    always_comb begin
        logic signed [EST_W-1:0] acc;
        logic signed [EST_W-1:0] tap;
        logic signed [EST_W-1:0] est;
        logic signed [ERR_W-1:0] est_ext;
        logic signed [ERR_W-1:0] code_ext;
        for (int i = 0; i < LANES; i++) begin
            acc = '0;
            for (int t = 0; t < CHAN_TAPS; t++) begin
                tap = cfg_i.chan_w[t];
                //Bit 1 maps to +1, bit 0 to -1
                if (bit_hist[LANES+i-t]) begin
                    acc = acc + tap;
                end else begin
                    acc = acc - tap;
                end
            end
            est      = acc >>> cfg_i.chan_shift;
            est_ext  = est;
            code_ext = codes_i[i];
            err_d[i] = est_ext - code_ext;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            err_o <= err_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

endmodule : channel_error

`default_nettype wire

//--- verilog/dsp_datapath_top.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_datapath_top (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [7:0]                 paddr_i,
    input  logic [31:0]                pwdata_i,
    output logic [31:0]                prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,

    input  logic                       data_valid_i,
    input  dsp_data_pkg::code_block_t  codes_i,
    output dsp_data_pkg::bit_block_t   bits_o,
    output dsp_data_pkg::err_block_t   err_o,
    output logic                       out_valid_o
);
    import dsp_data_pkg::*;
    import dsp_cfg_pkg::*;

    dsp_cfg_t                        cfg;
    code_window_t [LANES-1:0]        windows;
    bit_block_t                      ffe_bits;
    code_block_t                     codes_d1;
    logic                            valid_d1;

    apb_cfg_regs cfg_regs_i (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .cfg_o     (cfg)
    );

    code_history hist_i (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (data_valid_i),
        .codes_i   (codes_i),
        .windows_o (windows)
    );

    //One equalizer and slicer per lane
    for (genvar gi = 0; gi < LANES; gi++) begin : g_lane
        ffe_lane lane_i (
            .clk_i    (clk_i),
            .reset_i  (reset_i),
            .window_i (windows[gi]),
            .cfg_i    (cfg),
            .bit_o    (ffe_bits[gi])
        );
    end

    //Codes follow the slicer stage
    delay_line #(.payload_t(code_block_t), .DEPTH(1)) code_dly_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (data_valid_i),
        .data_i  (codes_i),
        .data_o  (codes_d1),
        .valid_o (valid_d1)
    );

    channel_error chan_err_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_d1),
        .bits_i  (ffe_bits),
        .codes_i (codes_d1),
        .cfg_i   (cfg),
        .err_o   (err_o),
        .valid_o (out_valid_o)
    );

    //Bits follow the error stage
    delay_line #(.payload_t(bit_block_t), .DEPTH(1)) bit_dly_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_d1),
        .data_i  (ffe_bits),
        .data_o  (bits_o),
        .valid_o ()
    );

endmodule : dsp_datapath_top

`default_nettype wire

//--- tests/dsp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_checker (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       data_valid_i,
    input  dsp_data_pkg::code_block_t  codes_i,
    input  dsp_cfg_pkg::dsp_cfg_t      cfg_i,
    input  logic                       out_valid_i,
    input  dsp_data_pkg::bit_block_t   bits_i,
    input  dsp_data_pkg::err_block_t   err_i,
    output int                         pending_o,
    output int                         checks_o,
    output int                         errors_o
);
    import dsp_data_pkg::*;
    import dsp_cfg_pkg::*;

    typedef struct packed {
        int         due;
        bit_block_t bits;
        err_block_t err;
    } expect_t;

    expect_t expect_q [$];
    expect_t exp;
    // Previous block in the low half, current block in the high half
    int      code_hist [2*LANES];
    logic    bit_hist [2*LANES];
    int      cycle;

    // Sample k belongs to lane k mod LANES
    // Taps reach back to sample k-t
    task automatic predict();
        int         acc;
        bit_block_t nb;
        err_block_t ne;
        for (int i = 0; i < LANES; i++) begin
            code_hist[LANES+i] = int'($signed(codes_i[i]));
        end
        for (int i = 0; i < LANES; i++) begin
            acc = 0;
            for (int t = 0; t < FFE_TAPS; t++) begin
                acc += int'($signed(cfg_i.ffe_w[t])) * code_hist[LANES+i-t];
            end
            nb[i] = (acc >>> cfg_i.ffe_shift) >= int'($signed(cfg_i.thresh));
            bit_hist[LANES+i] = nb[i];
        end
        for (int i = 0; i < LANES; i++) begin
            acc = 0;
            for (int t = 0; t < CHAN_TAPS; t++) begin
                acc += bit_hist[LANES+i-t] ? int'($signed(cfg_i.chan_w[t]))
                                           : -int'($signed(cfg_i.chan_w[t]));
            end
            ne[i] = err_t'((acc >>> cfg_i.chan_shift) - code_hist[LANES+i]);
        end
        for (int i = 0; i < LANES; i++) begin
            code_hist[i] = code_hist[LANES+i];
            bit_hist[i]  = bit_hist[LANES+i];
        end
        // Accepted at this edge and seen two edges later
        expect_q.push_back('{cycle + 2, nb, ne});
    endtask

    always @(posedge clk_i) begin
        cycle++;
        if (reset_i) begin
            expect_q.delete();
            code_hist = '{default: 0};
            bit_hist  = '{default: 1'b0};
        end else begin
            if (out_valid_i && expect_q.size() == 0) begin
                $display("Output block at cycle %0d without an input block in flight", cycle);
                errors_o++;
            end else if (out_valid_i) begin
                exp = expect_q.pop_front();
                checks_o++;
                if (exp.due != cycle) begin
                    $display("Output block at cycle %0d, expected at cycle %0d", cycle, exp.due);
                    errors_o++;
                end
                if (bits_i !== exp.bits) begin
                    $display("FAIL bits_o got 0x%h expected 0x%h", bits_i, exp.bits);
                    errors_o++;
                end
                if (err_i !== exp.err) begin
                    $display("FAIL err_o got 0x%h expected 0x%h", err_i, exp.err);
                    errors_o++;
                end
            end else if (expect_q.size() != 0 && expect_q[0].due <= cycle) begin
                $display("No output block at cycle %0d for an accepted input block", cycle);
                errors_o++;
                void'(expect_q.pop_front());
            end
            if (data_valid_i) begin
                predict();
            end
        end
        pending_o = expect_q.size();
    end

endmodule : dsp_checker

`default_nettype wire

//--- tests/tb_dsp_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_datapath;
    import dsp_data_pkg::*;
    import dsp_cfg_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int SEED       = 95559;
    localparam int NUM_TESTS  = 6;
    localparam int SLACK      = 40;

    localparam logic [1:0] MODE_FIXED = 2'd0;
    localparam logic [1:0] MODE_RAND  = 2'd1;
    localparam logic [1:0] MODE_GAPS  = 2'd2;

    localparam logic [3:0][7:0] REG_ADDR = {ADDR_CHAN_SHIFT, ADDR_CHAN, ADDR_FFE_CTL, ADDR_FFE_W};

    typedef struct packed {
        logic [3:0][31:0] wr;
        logic [3:0][31:0] rd;
        int               blocks;
        logic [1:0]       mode;
    } test_t;

    // Register values run from 0x0C down to 0x00
    localparam test_t TESTS [NUM_TESTS] = '{
        '{{32'h0, 32'h0, 32'h0, 32'h0}, {32'h0, 32'h0, 32'h0, 32'h0}, 8, MODE_FIXED},
        '{{32'h0, 32'h0, 32'h0, 32'h1}, {32'h0, 32'h0, 32'h0, 32'h1}, 8, MODE_FIXED},
        '{{32'h0, 32'h0, 32'h000F_F600, 32'h1}, {32'h0, 32'h0, 32'h000F_F600, 32'h1},
          16, MODE_RAND},
        '{{32'h0, 32'h0, 32'h0000_0503, 32'h0008_F020},
          {32'h0, 32'h0, 32'h0000_0503, 32'h0008_F020}, 24, MODE_RAND},
        '{{32'h1, 32'h0010_E040, 32'h0, 32'h1}, {32'h1, 32'h0010_E040, 32'h0, 32'h1},
          24, MODE_RAND},
        '{{32'hFFFF_FFF2, 32'h5508_C020, 32'hA000_5002, 32'hFFF8_4010},
          {32'h2, 32'h0008_C020, 32'h0000_5002, 32'h00F8_4010}, 10, MODE_GAPS}
    };

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        data_valid;
    code_block_t codes;
    bit_block_t  bits;
    err_block_t  err;
    logic        out_valid;
    dsp_cfg_t    model_cfg;
    int          pending;
    int          checks;
    int          errors;
    int          bus_errors;
    int          cycle_limit;
    int          cycle_count;

    dsp_datapath_top dut_i (
        .clk_i (clk), .reset_i (reset),
        .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
        .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
        .data_valid_i (data_valid), .codes_i (codes),
        .bits_o (bits), .err_o (err), .out_valid_o (out_valid)
    );

    dsp_checker chk_i (
        .clk_i (clk), .reset_i (reset), .data_valid_i (data_valid), .codes_i (codes),
        .cfg_i (model_cfg), .out_valid_i (out_valid), .bits_i (bits), .err_i (err),
        .pending_o (pending), .checks_o (checks), .errors_o (errors)
    );

    function automatic dsp_cfg_t regs_to_cfg(input logic [3:0][31:0] wr);
        dsp_cfg_t c;
        c.ffe_w      = wr[0][23:0];
        c.ffe_shift  = wr[1][2:0];
        c.thresh     = wr[1][19:8];
        c.chan_w     = wr[2][23:0];
        c.chan_shift = wr[3][2:0];
        return c;
    endfunction

    function automatic code_block_t make_block(input logic [1:0] mode, input int blk);
        code_block_t b;
        for (int i = 0; i < LANES; i++) begin
            b[i] = (mode == MODE_FIXED) ? code_t'((blk * LANES + i) * 37 - 100) : code_t'($urandom);
        end
        return b;
    endfunction

    // Setup edge then access edge
    // The next call ends the access phase
    task automatic bus_check(input logic write, input logic [7:0] addr,
                             input logic [31:0] data, input logic exp_err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= write ? data : 32'h0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        if (!write && prdata !== data) begin
            $display("FAIL prdata_o at 0x%h got 0x%h expected 0x%h", addr, prdata, data);
            bus_errors++;
        end
        if (pslverr !== exp_err) begin
            $display("FAIL pslverr_o at 0x%h got 0x%h expected 0x%h", addr, pslverr, exp_err);
            bus_errors++;
        end
        if (pready !== 1'b1) begin
            $display("FAIL pready_o at 0x%h got 0x%h expected 0x1", addr, pready);
            bus_errors++;
        end
    endtask

    task automatic run_test(input int idx);
        test_t t;
        int    checks0;
        int    errors0;
        t       = TESTS[idx];
        checks0 = checks;
        errors0 = errors + bus_errors;
        for (int r = 0; r < 4; r++) begin
            bus_check(1'b1, REG_ADDR[r], t.wr[r], 1'b0);
        end
        bus_check(1'b1, 8'h10, 32'hFFFF_FFFF, 1'b1);
        bus_check(1'b0, 8'h10, 32'h0, 1'b1);
        for (int r = 0; r < 4; r++) begin
            bus_check(1'b0, REG_ADDR[r], t.rd[r], 1'b0);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        model_cfg = regs_to_cfg(t.wr);
        for (int b = 0; b < t.blocks; b++) begin
            @(posedge clk);
            data_valid <= 1'b1;
            codes      <= make_block(t.mode, b);
            if (t.mode == MODE_GAPS && $urandom_range(1) != 0) begin
                @(posedge clk);
                data_valid <= 1'b0;
            end
        end
        @(posedge clk);
        data_valid <= 1'b0;
        do @(negedge clk); while (pending != 0);
        $display("Test %0d: %0d blocks checked, %0d errors", idx, checks - checks0,
                 errors + bus_errors - errors0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycle_limit = SLACK * NUM_TESTS;
        for (int i = 0; i < NUM_TESTS; i++) begin
            cycle_limit += TESTS[i].blocks;
        end
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        data_valid = 1'b0;
        codes      = '0;
        model_cfg  = '0;
        bus_errors = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("Totals: %0d blocks checked, %0d data errors, %0d bus errors",
                 checks, errors, bus_errors);
        if (errors == 0 && bus_errors == 0 && checks > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_dsp_datapath

`default_nettype wire

//--- files.f
verilog/dsp_cfg_pkg.sv
verilog/dsp_data_pkg.sv
verilog/apb_cfg_regs.sv
verilog/code_history.sv
verilog/ffe_lane.sv
verilog/delay_line.sv
verilog/channel_error.sv
verilog/dsp_datapath_top.sv
tests/dsp_checker.sv
tests/tb_dsp_datapath.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_dsp_datapath
RTL_TOP    := dsp_datapath_top
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	rm -f $(LOG)
	-$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
